// File: hdl/zx_pkg.sv
package zx_pkg;

	// ============================================================
	// Bus and memory transfer types
	// ============================================================

	// One CPU bus cycle
	typedef struct packed {
		logic [15:0] addr;
		logic        is_io;  // IO cycle, else memory
		logic        write;
		logic [7:0]  wdata;
	} bus_req_t;

	typedef struct packed {
		logic [7:0] rdata;
	} bus_rsp_t;

	// External memory request, byte wide
	typedef struct packed {
		logic [23:0] addr;
		logic        write;
		logic [7:0]  wdata;
	} mem_req_t;

	// Paging state seen by the mapper
	typedef struct packed {
		logic [7:0] page_reg;        // Port 7FFD
		logic [7:0] page_reg_plus3;  // Port 1FFD
		logic       zx48;
		logic       plus3;
	} paging_t;

	// ============================================================
	// Configuration codes
	// ============================================================

	// Unlisted codes behave as MODE_128K
	typedef enum logic [2:0] {
		MODE_128K  = 3'd0,
		MODE_48K   = 3'd3,
		MODE_PLUS3 = 3'd4
	} mem_mode_t;

	typedef logic [2:0] cpu_speed_t;

	localparam cpu_speed_t SPEED_3M5 = 3'd0;
	localparam cpu_speed_t SPEED_7M  = 3'd1;
	localparam cpu_speed_t SPEED_14M = 3'd2;
	localparam cpu_speed_t SPEED_28M = 3'd3;
	localparam cpu_speed_t SPEED_56M = 3'd4;

	// ============================================================
	// Memory layout
	// ============================================================
	localparam logic [23:0] ROM_BASE = 24'h140000;  // ROM page 0
	localparam logic [23:0] RAM_BASE = 24'h000000;  // RAM page 0
	localparam int          PAGE_BITS = 14;         // 16K page

	localparam logic [7:0] IO_READ_DATA = 8'hFF;  // Idle bus value

endpackage

// File: hdl/bus_slot.sv
module bus_slot #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	payload_t data;
	logic     full;

	assign in_ready  = !full;  // Accept only when empty
	assign out_valid = full;
	assign out_data  = data;

	always_ff @(posedge clk_sys) begin
		if (reset)
			full <= 1'b0;
		else if (in_valid && in_ready)
			full <= 1'b1;
		else if (out_valid && out_ready)
			full <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (in_valid && in_ready)
			data <= in_data;
	end

endmodule

// File: hdl/cpu_clock_gen.sv
module cpu_clock_gen import zx_pkg::*; #(
	parameter int SETTLE_TICKS = 3
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_speed_t cpu_speed,
	output logic       cpu_ce
);

	localparam int SW = $clog2(SETTLE_TICKS + 2);

	logic [4:0]    counter;     // Free running
	logic [4:0]    mask_req;
	logic [4:0]    mask_cur;    // Applied rate
	logic [SW-1:0] settle;      // New-rate periods still to wait
	logic          period_end;

	// Period is 32, 16, 8, 4 or 2 cycles
	always_comb begin
		case (cpu_speed)
			SPEED_3M5: mask_req = 5'b11111;
			SPEED_7M:  mask_req = 5'b01111;
			SPEED_14M: mask_req = 5'b00111;
			SPEED_28M: mask_req = 5'b00011;
			SPEED_56M: mask_req = 5'b00001;
			default:   mask_req = 5'b11111;  // Unused codes run at 3.5 MHz
		endcase
	end

	assign period_end = (counter & mask_cur) == 5'd0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter  <= '0;
			mask_cur <= 5'b11111;
			settle   <= '0;
			cpu_ce   <= 1'b0;
		end else begin
			counter <= counter + 5'd1;
			cpu_ce  <= 1'b0;
			if (mask_req != mask_cur) begin
				// Rate change, hold off the CPU
				mask_cur <= mask_req;
				settle   <= SW'(SETTLE_TICKS);
			end else if (period_end) begin
				if (settle != '0)
					settle <= settle - 1'b1;
				else
					cpu_ce <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/bus_sequencer.sv
module bus_sequencer import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cpu_ce,
	input  bus_req_t    bus_req,
	input  logic        bus_req_valid,
	output logic        bus_req_ready,
	output bus_rsp_t    rsp_data,
	output logic        rsp_valid,
	input  logic        rsp_ready,
	output mem_req_t    req_data,
	output logic        req_valid,
	input  logic        req_ready,
	input  logic [7:0]  mem_rdata,
	input  logic        mem_rsp_valid,
	output logic        page_wr,
	output logic [15:0] page_addr,
	output logic [7:0]  page_wdata,
	output logic [15:0] cpu_addr,
	input  logic [23:0] mapped_addr,
	input  logic        write_allowed
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_MEM,
		RESPOND
	} state_t;

	state_t     state;
	bus_req_t   hold;      // Accepted cycle
	logic [7:0] rdata;
	logic       accept;
	logic       refused;

	// One cycle per CPU clock-enable, only with room for the response
	assign bus_req_ready = (state == IDLE) && cpu_ce && rsp_ready;
	assign accept        = bus_req_valid && bus_req_ready;
	assign refused       = hold.write && !write_allowed;  // ROM write

	assign cpu_addr = hold.addr;

	// ============================================================
	// Control
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:
					if (accept)
						state <= bus_req.is_io ? RESPOND : ISSUE;
				ISSUE:
					if (refused)
						state <= RESPOND;  // Skip memory
					else if (req_ready)
						state <= WAIT_MEM;
				WAIT_MEM:
					if (mem_rsp_valid)
						state <= RESPOND;
				RESPOND:
					if (rsp_ready)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			hold  <= bus_req;
			rdata <= IO_READ_DATA;  // IO reads and refused writes
		end else if (state == WAIT_MEM && mem_rsp_valid) begin
			rdata <= mem_rdata;
		end
	end

	// ============================================================
	// Outputs
	// ============================================================
	assign req_valid      = (state == ISSUE) && !refused;
	assign req_data.addr  = mapped_addr;
	assign req_data.write = hold.write;
	assign req_data.wdata = hold.wdata;

	assign rsp_valid      = (state == RESPOND);
	assign rsp_data.rdata = rdata;

	// Single pulse as the IO write completes
	assign page_wr    = (state == RESPOND) && rsp_ready && hold.is_io && hold.write;
	assign page_addr  = hold.addr;
	assign page_wdata = hold.wdata;

endmodule

// File: hdl/paging_regs.sv
module paging_regs import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  mem_mode_t   mem_mode,
	input  logic        page_wr,
	input  logic [15:0] page_addr,
	input  logic [7:0]  page_wdata,
	output paging_t     paging
);

	logic [7:0] page_reg;        // 7FFD
	logic [7:0] page_reg_plus3;  // 1FFD
	logic       zx48;
	logic       plus3;

	logic       mode_zx48;
	logic       mode_plus3;
	logic       page_disable;
	logic       write_7ffd;
	logic       write_1ffd;

	// Mode as latched at reset
	always_comb begin
		case (mem_mode)
			MODE_128K: begin
				mode_zx48  = 1'b0;
				mode_plus3 = 1'b0;
			end
			MODE_48K: begin
				mode_zx48  = 1'b1;
				mode_plus3 = 1'b0;
			end
			MODE_PLUS3: begin
				mode_zx48  = 1'b0;
				mode_plus3 = 1'b1;
			end
			default: begin  // Behaves as 128K
				mode_zx48  = 1'b0;
				mode_plus3 = 1'b0;
			end
		endcase
	end

	// Bit 5 locks paging until reset
	assign page_disable = zx48 | page_reg[5];

	// ============================================================
	// Port decode
	// ============================================================
	assign write_7ffd = ~page_addr[15] & ~page_addr[1] & (page_addr[14] | ~plus3) &
		~page_disable;
	assign write_1ffd = ~page_addr[15] & ~page_addr[14] & ~page_addr[13] & ~page_addr[1] &
		page_addr[12] & plus3 & ~page_disable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			zx48           <= mode_zx48;
			plus3          <= mode_plus3;
		end else if (page_wr) begin
			if (write_7ffd)
				page_reg <= page_wdata;
			else if (write_1ffd)
				page_reg_plus3 <= page_wdata;
		end
	end

	assign paging = '{
		page_reg:       page_reg,
		page_reg_plus3: page_reg_plus3,
		zx48:           zx48,
		plus3:          plus3
	};

endmodule

// File: hdl/addr_mapper.sv
module addr_mapper import zx_pkg::*; (
	input  paging_t     paging,
	input  logic [15:0] cpu_addr,
	output logic [23:0] mapped_addr,
	output logic        write_allowed
);

	logic [1:0]           quarter;
	logic [PAGE_BITS-1:0] offset;
	logic                 special;   // All-RAM mode of the +3
	logic [1:0]           config_sel;
	logic [3:0]           rom_page;
	logic [2:0]           ram_page;
	logic                 is_rom;

	assign quarter    = cpu_addr[15:14];
	assign offset     = cpu_addr[PAGE_BITS-1:0];
	assign special    = paging.page_reg_plus3[0];
	assign config_sel = paging.page_reg_plus3[2:1];

	// ROM page, +3 pages 8 to 11
	always_comb begin
		if (paging.plus3)
			rom_page = {2'b10, paging.page_reg_plus3[2], paging.page_reg[4]};
		else if (paging.zx48)
			rom_page = 4'd15;
		else
			rom_page = 4'd7 + {3'd0, paging.page_reg[4]};
	end

	always_comb begin
		if (special) begin
			case (quarter)
				2'd0:    ram_page = (config_sel == 2'd0) ? 3'd0 : 3'd4;
				2'd1:    ram_page = (config_sel == 2'd0) ? 3'd1 :
				                    (config_sel == 2'd3) ? 3'd7 : 3'd5;
				2'd2:    ram_page = (config_sel == 2'd0) ? 3'd2 : 3'd6;
				default: ram_page = (config_sel == 2'd1) ? 3'd7 : 3'd3;
			endcase
		end else begin
			case (quarter)
				2'd1:    ram_page = 3'd5;
				2'd2:    ram_page = 3'd2;
				default: ram_page = paging.page_reg[2:0];  // Top window
			endcase
		end
	end

	assign is_rom = !special && (quarter == 2'd0);

	assign mapped_addr = is_rom ?
		ROM_BASE + ((24'(rom_page) << PAGE_BITS) | 24'(offset)) :
		RAM_BASE + ((24'(ram_page) << PAGE_BITS) | 24'(offset));

	assign write_allowed = !is_rom;  // ROM is read only

endmodule

// File: hdl/zx_mem_top.sv
module zx_mem_top import zx_pkg::*; #(
	parameter int SETTLE_TICKS = 3
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  bus_req_t   bus_req,
	input  logic       bus_req_valid,
	output logic       bus_req_ready,
	output bus_rsp_t   bus_rsp,
	output logic       bus_rsp_valid,
	input  logic       bus_rsp_ready,
	output mem_req_t   mem_req,
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	input  logic [7:0] mem_rdata,
	input  logic       mem_rsp_valid,
	input  cpu_speed_t cpu_speed,
	input  mem_mode_t  mem_mode,
	output logic       cpu_ce
);

	mem_req_t    req_data;
	logic        req_valid;
	logic        req_ready;
	bus_rsp_t    rsp_data;
	logic        rsp_valid;
	logic        rsp_ready;

	logic        page_wr;
	logic [15:0] page_addr;
	logic [7:0]  page_wdata;
	paging_t     paging;

	logic [15:0] cpu_addr;
	logic [23:0] mapped_addr;
	logic        write_allowed;

	cpu_clock_gen #(.SETTLE_TICKS(SETTLE_TICKS)) cpu_clock_gen_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_speed(cpu_speed),
		.cpu_ce  (cpu_ce)
	);

	bus_sequencer bus_sequencer_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.bus_req      (bus_req),
		.bus_req_valid(bus_req_valid),
		.bus_req_ready(bus_req_ready),
		.rsp_data     (rsp_data),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.req_data     (req_data),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.mem_rdata    (mem_rdata),
		.mem_rsp_valid(mem_rsp_valid),
		.page_wr      (page_wr),
		.page_addr    (page_addr),
		.page_wdata   (page_wdata),
		.cpu_addr     (cpu_addr),
		.mapped_addr  (mapped_addr),
		.write_allowed(write_allowed)
	);

	paging_regs paging_regs_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mem_mode  (mem_mode),
		.page_wr   (page_wr),
		.page_addr (page_addr),
		.page_wdata(page_wdata),
		.paging    (paging)
	);

	addr_mapper addr_mapper_i (
		.paging       (paging),
		.cpu_addr     (cpu_addr),
		.mapped_addr  (mapped_addr),
		.write_allowed(write_allowed)
	);

	// Towards external memory
	bus_slot #(.payload_t(mem_req_t)) req_slot_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_data  (req_data),
		.in_valid (req_valid),
		.in_ready (req_ready),
		.out_data (mem_req),
		.out_valid(mem_req_valid),
		.out_ready(mem_req_ready)
	);

	// Towards the CPU side
	bus_slot #(.payload_t(bus_rsp_t)) rsp_slot_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_data  (rsp_data),
		.in_valid (rsp_valid),
		.in_ready (rsp_ready),
		.out_data (bus_rsp),
		.out_valid(bus_rsp_valid),
		.out_ready(bus_rsp_ready)
	);

endmodule

// File: bench/zx_mem_props.sv
module zx_mem_props import zx_pkg::*; #(
	parameter int SETTLE_TICKS = 3
) (
	input logic       clk_sys,
	input logic       reset,
	input logic       bus_req_ready,
	input bus_rsp_t   bus_rsp,
	input logic       bus_rsp_valid,
	input logic       bus_rsp_ready,
	input mem_req_t   mem_req,
	input logic       mem_req_valid,
	input logic       mem_req_ready,
	input logic       mem_rsp_valid,
	input cpu_speed_t cpu_speed,
	input logic       cpu_ce
);

	timeunit 1ns;
	timeprecision 100ps;

	logic       outstanding;  // Memory request in flight
	cpu_speed_t last_speed;
	int         quiet;        // Cycles that must stay without cpu_ce

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			outstanding <= 1'b0;
			last_speed  <= cpu_speed;
			quiet       <= 0;
		end else begin
			last_speed <= cpu_speed;
			if (mem_req_valid && mem_req_ready)
				outstanding <= 1'b1;
			else if (mem_rsp_valid)
				outstanding <= 1'b0;
			// Settle periods at the new rate
			if (cpu_speed != last_speed)
				quiet <= SETTLE_TICKS * ((cpu_speed <= 3'd4) ? (32 >> cpu_speed) : 32);
			else if (quiet != 0)
				quiet <= quiet - 1;
		end
	end

	ready_with_ce: assert property (@(posedge clk_sys) disable iff (reset)
		bus_req_ready |-> cpu_ce && !bus_rsp_valid)
		else $error("bus_req_ready high without cpu_ce or with a response pending");

	rsp_stable: assert property (@(posedge clk_sys) disable iff (reset)
		bus_rsp_valid && !bus_rsp_ready |=> bus_rsp_valid && $stable(bus_rsp))
		else $error("bus_rsp dropped or changed before it was taken");

	req_stable: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else $error("mem_req dropped or changed before it was taken");

	one_outstanding: assert property (@(posedge clk_sys) disable iff (reset)
		outstanding |-> !mem_req_valid)
		else $error("second memory request while one is outstanding");

	settle_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		quiet != 0 |-> !cpu_ce)
		else $error("cpu_ce during the settle interval");

endmodule

// File: bench/tb_zx_mem.sv
module tb_zx_mem import zx_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SETTLE_TICKS = 3;
	localparam int MAX_VECTORS  = 64;
	localparam int CYCLES_PER_VECTOR = 400;  // Slowest rate plus settle and memory latency

	logic        clk_sys;
	logic        reset;
	bus_req_t    bus_req;
	logic        bus_req_valid;
	logic        bus_req_ready;
	bus_rsp_t    bus_rsp;
	logic        bus_rsp_valid;
	logic        bus_rsp_ready = 1'b0;
	mem_req_t    mem_req;
	logic        mem_req_valid;
	logic        mem_req_ready = 1'b0;
	logic [7:0]  mem_rdata     = 8'h00;
	logic        mem_rsp_valid = 1'b0;
	cpu_speed_t  cpu_speed;
	mem_mode_t   mem_mode;
	logic        cpu_ce;

	logic [35:0] vectors [0:MAX_VECTORS-1];  // kind, addr, wdata, expected
	logic [7:0]  mem [logic [23:0]];         // Only written bytes stored
	logic [15:0] lfsr = 16'd47;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit  = 100000;
	int          num_vectors;
	cpu_speed_t  cur_speed;

	logic        mem_busy  = 1'b0;
	int          mem_delay = 0;
	logic [7:0]  pend_rdata;

	zx_mem_top #(.SETTLE_TICKS(SETTLE_TICKS)) zx_mem_top_i (.*);

	bind zx_mem_top zx_mem_props #(.SETTLE_TICKS(SETTLE_TICKS)) zx_mem_props_i (
		.clk_sys(clk_sys), .reset(reset), .bus_req_ready(bus_req_ready),
		.bus_rsp(bus_rsp), .bus_rsp_valid(bus_rsp_valid), .bus_rsp_ready(bus_rsp_ready),
		.mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid), .cpu_speed(cpu_speed), .cpu_ce(cpu_ce)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Random source and memory contents
	// ============================================================
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	// Untouched bytes read as a pattern of the full address
	function automatic logic [7:0] fill_byte(input logic [23:0] a);
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
	endfunction

	function automatic logic [7:0] read_mem(input logic [23:0] a);
		return mem.exists(a) ? mem[a] : fill_byte(a);
	endfunction

	// External memory with random latency, plus CPU side back-pressure
	always @(posedge clk_sys) begin
		if (reset) begin
			mem_req_ready <= 1'b0;
			mem_rsp_valid <= 1'b0;
			bus_rsp_ready <= 1'b0;
			mem_busy = 1'b0;
		end else begin
			bus_rsp_ready <= take_bits(2) != 8'd0;  // Ready three times in four
			mem_rsp_valid <= 1'b0;
			if (mem_busy) begin
				if (mem_delay == 0) begin
					mem_rsp_valid <= 1'b1;
					mem_rdata     <= pend_rdata;
					mem_busy = 1'b0;
				end else begin
					mem_delay = mem_delay - 1;
				end
			end else if (mem_req_valid && mem_req_ready) begin
				mem_busy = 1'b1;
				mem_req_ready <= 1'b0;  // One request at a time
				mem_delay = int'(take_bits(3));
				if (mem_req.write) begin
					mem[mem_req.addr] = mem_req.wdata;
					pend_rdata = 8'h00;
				end else begin
					pend_rdata = read_mem(mem_req.addr);
				end
			end else begin
				mem_req_ready <= take_bits(1) != 8'd0;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// ============================================================
	// Checks and stimulus tasks
	// ============================================================
	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic apply_mode(input logic [2:0] mode);
		@(posedge clk_sys);
		mem_mode <= mem_mode_t'(mode);
		reset    <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic measure_speed(input int idx, input cpu_speed_t s);
		int period;
		int gap;
		period = (s <= 3'd4) ? (32 >> s) : 32;
		@(posedge clk_sys);
		cpu_speed <= s;
		@(negedge clk_sys);  // A pulse here was set by the old rate
		gap = 1;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!cpu_ce);
		if (s != cur_speed)
			check_value($sformatf("vec%0d settle gap %0d", idx, gap), 1,
				int'(gap >= SETTLE_TICKS * period));
		cur_speed = s;
		repeat (3) begin
			gap = 0;
			do begin
				@(negedge clk_sys);
				gap++;
			end while (!cpu_ce);
			check_value($sformatf("vec%0d ce spacing speed %0d", idx, s), period, gap);
		end
	endtask

	task automatic run_cycle(input int idx, input logic [3:0] kind, input logic [15:0] addr,
		input logic [7:0] wdata, input logic [7:0] expected);
		bus_rsp_t got;
		@(posedge clk_sys);
		bus_req <= '{addr: addr, is_io: kind >= 4'd4, write: kind == 4'd3 || kind == 4'd5,
			wdata: wdata};
		bus_req_valid <= 1'b1;
		do @(negedge clk_sys); while (!bus_req_ready);
		@(posedge clk_sys);
		bus_req_valid <= 1'b0;
		do @(negedge clk_sys); while (!(bus_rsp_valid && bus_rsp_ready));
		got = bus_rsp;
		check_value($sformatf("vec%0d kind %0d addr %h", idx, kind, addr), expected, got.rdata);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		reset         = 1'b1;
		bus_req       = '0;
		bus_req_valid = 1'b0;
		cpu_speed     = SPEED_3M5;
		mem_mode      = MODE_128K;
		cur_speed     = SPEED_3M5;
		foreach (vectors[i])
			vectors[i] = '1;
		$readmemh("bench/zx_mem_vectors.txt", vectors);
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS && vectors[num_vectors][35:32] != 4'hF)
			num_vectors++;
		limit = num_vectors * CYCLES_PER_VECTOR + 200;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		for (int i = 0; i < num_vectors; i++) begin
			case (vectors[i][35:32])
				4'h0:    measure_speed(i, vectors[i][18:16]);
				4'h1:    apply_mode(vectors[i][18:16]);
				default: run_cycle(i, vectors[i][35:32], vectors[i][31:16], vectors[i][15:8],
					vectors[i][7:0]);
			endcase
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: bench/zx_mem_vectors.txt
// Columns: kind(1) addr(4) wdata(2) expected rdata(2)
// kind 0 speed, 1 mode and reset, 2 mem read, 3 mem write, 4 IO read, 5 IO write, F end
0_0001_00_00
0_0002_00_00
0_0003_00_00
0_0000_00_00
0_0004_00_00
// 128K mode
1_0000_00_00
2_0000_00_70
2_4000_00_E4
2_8000_00_25
2_C000_00_A5
2_4123_00_C6
3_0000_5A_FF
2_0000_00_70
3_C010_3C_00
2_C010_00_3C
4_00FE_00_FF
5_7FFD_13_FF
2_C000_00_65
2_0000_00_B3
5_7FFD_21_FF
2_C000_00_E5
2_0000_00_70
5_7FFD_17_FF
2_C000_00_E5
// +3 mode
1_0004_00_00
2_0000_00_B3
5_1FFD_04_FF
2_0000_00_33
5_7FFD_10_FF
2_0000_00_73
5_1FFD_01_FF
2_4000_00_E5
3_0020_77_00
2_0020_00_77
5_1FFD_03_FF
2_0000_00_A4
2_C000_00_64
5_1FFD_05_FF
2_C000_00_65
5_1FFD_07_FF
2_4000_00_64
2_8000_00_24
// 48K mode
1_0003_00_00
2_0000_00_72
5_7FFD_03_FF
2_C000_00_A5
F_0000_00_00

// File: zx_mem_top.f
hdl/zx_pkg.sv
hdl/bus_slot.sv
hdl/cpu_clock_gen.sv
hdl/bus_sequencer.sv
hdl/paging_regs.sv
hdl/addr_mapper.sv
hdl/zx_mem_top.sv
bench/zx_mem_props.sv
bench/tb_zx_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -u
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_mem \
	-f zx_mem_top.f -o tb_zx_mem
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/tb_zx_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -qx "Regression passed" "$LOG"; then
	exit 0
fi
exit 1
